// ==== src/message_layout_pkg.sv ====
`default_nettype none

package message_layout_pkg;

    localparam int message_width = 32;

    typedef logic [message_width-1:0] message_t;

    typedef enum logic [1:0] {
        kind_none = 2'd0,
        kind_a    = 2'd1,
        kind_d    = 2'd2,
        kind_k    = 2'd3
    } message_kind_e;

    // Header, same place in every kind.
    localparam int hdr_pid1_hi = 31;
    localparam int hdr_pid1_lo = 31;
    localparam int hdr_mc1_hi  = 30;
    localparam int hdr_mc1_lo  = 30;
    localparam int hdr_mt1_hi  = 29;
    localparam int hdr_mt1_lo  = 29;

    localparam int a_ss5_hi   = 28;
    localparam int a_ss5_lo   = 24;
    localparam int a_sp4_hi   = 23;
    localparam int a_sp4_lo   = 20;
    localparam int a_v4_hi    = 19;
    localparam int a_v4_lo    = 16;
    localparam int a_ti4_hi   = 15;
    localparam int a_ti4_lo   = 12;
    localparam int a_ppdc1_hi = 11;
    localparam int a_ppdc1_lo = 11;

    localparam int d_ss5_hi  = 28;
    localparam int d_ss5_lo  = 24;
    localparam int d_sp4_hi  = 23;
    localparam int d_sp4_lo  = 20;
    localparam int d_oiv4_hi = 19;
    localparam int d_oiv4_lo = 16;

    // Kind k swaps SP4 and SS5.
    localparam int k_sp4_hi   = 28;
    localparam int k_sp4_lo   = 25;
    localparam int k_ss5_hi   = 24;
    localparam int k_ss5_lo   = 20;
    localparam int k_bp4_hi   = 19;
    localparam int k_bp4_lo   = 16;
    localparam int k_bs4_hi   = 15;
    localparam int k_bs4_lo   = 12;
    localparam int k_ppdc1_hi = 11;
    localparam int k_ppdc1_lo = 11;

endpackage

`default_nettype wire

// ==== src/field_pkg.sv ====
`default_nettype none

package field_pkg;

    typedef logic       flag_t;
    typedef logic [4:0] ss_t;
    typedef logic [3:0] nibble_t;

    localparam int num_fields = 11;

    // Bit index of each field in a hit or write enable vector.
    localparam int fld_pid1  = 0;
    localparam int fld_mc1   = 1;
    localparam int fld_mt1   = 2;
    localparam int fld_ss5   = 3;
    localparam int fld_sp4   = 4;
    localparam int fld_v4    = 5;
    localparam int fld_ti4   = 6;
    localparam int fld_ppdc1 = 7;
    localparam int fld_oiv4  = 8;
    localparam int fld_bp4   = 9;
    localparam int fld_bs4   = 10;

    typedef logic [num_fields-1:0] field_hit_t;

endpackage

`default_nettype wire

// ==== src/message_slot_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module message_slot_decode
    import message_layout_pkg::*;
    import field_pkg::*;
(
    input  message_t      message,
    input  message_kind_e kind,
    output field_hit_t    field_hit,
    output flag_t         pid1,
    output flag_t         mc1,
    output flag_t         mt1,
    output flag_t         ppdc1,
    output ss_t           ss5,
    output nibble_t       sp4,
    output nibble_t       v4,
    output nibble_t       ti4,
    output nibble_t       oiv4,
    output nibble_t       bp4,
    output nibble_t       bs4
);

    always_comb begin
        field_hit = '0;
        pid1      = '0;
        mc1       = '0;
        mt1       = '0;
        ppdc1     = '0;
        ss5       = '0;
        sp4       = '0;
        v4        = '0;
        ti4       = '0;
        oiv4      = '0;
        bp4       = '0;
        bs4       = '0;

        if (kind != kind_none) begin
            field_hit[fld_pid1] = 1'b1;
            field_hit[fld_mc1]  = 1'b1;
            field_hit[fld_mt1]  = 1'b1;
            pid1 = message[hdr_pid1_hi:hdr_pid1_lo];
            mc1  = message[hdr_mc1_hi:hdr_mc1_lo];
            mt1  = message[hdr_mt1_hi:hdr_mt1_lo];
        end

        case (kind)
            kind_a: begin
                field_hit[fld_ss5]   = 1'b1;
                field_hit[fld_sp4]   = 1'b1;
                field_hit[fld_v4]    = 1'b1;
                field_hit[fld_ti4]   = 1'b1;
                field_hit[fld_ppdc1] = 1'b1;
                ss5   = message[a_ss5_hi:a_ss5_lo];
                sp4   = message[a_sp4_hi:a_sp4_lo];
                v4    = message[a_v4_hi:a_v4_lo];
                ti4   = message[a_ti4_hi:a_ti4_lo];
                ppdc1 = message[a_ppdc1_hi:a_ppdc1_lo];
            end
            kind_d: begin
                field_hit[fld_ss5]  = 1'b1;
                field_hit[fld_sp4]  = 1'b1;
                field_hit[fld_oiv4] = 1'b1;
                ss5  = message[d_ss5_hi:d_ss5_lo];
                sp4  = message[d_sp4_hi:d_sp4_lo];
                oiv4 = message[d_oiv4_hi:d_oiv4_lo];
            end
            kind_k: begin
                field_hit[fld_ss5]   = 1'b1;
                field_hit[fld_sp4]   = 1'b1;
                field_hit[fld_bp4]   = 1'b1;
                field_hit[fld_bs4]   = 1'b1;
                field_hit[fld_ppdc1] = 1'b1;
                ss5   = message[k_ss5_hi:k_ss5_lo];
                sp4   = message[k_sp4_hi:k_sp4_lo];
                bp4   = message[k_bp4_hi:k_bp4_lo];
                bs4   = message[k_bs4_hi:k_bs4_lo];
                ppdc1 = message[k_ppdc1_hi:k_ppdc1_lo];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/field_priority_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module field_priority_merge
    import field_pkg::*;
(
    input  field_hit_t hit_1,
    input  field_hit_t hit_2,
    input  field_hit_t hit_3,
    input  flag_t      pid1_1,  pid1_2,  pid1_3,
    input  flag_t      mc1_1,   mc1_2,   mc1_3,
    input  flag_t      mt1_1,   mt1_2,   mt1_3,
    input  flag_t      ppdc1_1, ppdc1_2, ppdc1_3,
    input  ss_t        ss5_1,   ss5_2,   ss5_3,
    input  nibble_t    sp4_1,   sp4_2,   sp4_3,
    input  nibble_t    v4_1,    v4_2,    v4_3,
    input  nibble_t    ti4_1,   ti4_2,   ti4_3,
    input  nibble_t    oiv4_1,  oiv4_2,  oiv4_3,
    input  nibble_t    bp4_1,   bp4_2,   bp4_3,
    input  nibble_t    bs4_1,   bs4_2,   bs4_3,
    output field_hit_t field_we,
    output flag_t      pid1_next,
    output flag_t      mc1_next,
    output flag_t      mt1_next,
    output flag_t      ppdc1_next,
    output ss_t        ss5_next,
    output nibble_t    sp4_next,
    output nibble_t    v4_next,
    output nibble_t    ti4_next,
    output nibble_t    oiv4_next,
    output nibble_t    bp4_next,
    output nibble_t    bs4_next
);

    assign field_we = hit_1 | hit_2 | hit_3;

    // Highest slot wins; slot 1 is the fallback and only matters when it hits.
    assign pid1_next  = hit_3[fld_pid1]  ? pid1_3  :
                        hit_2[fld_pid1]  ? pid1_2  : pid1_1;
    assign mc1_next   = hit_3[fld_mc1]   ? mc1_3   :
                        hit_2[fld_mc1]   ? mc1_2   : mc1_1;
    assign mt1_next   = hit_3[fld_mt1]   ? mt1_3   :
                        hit_2[fld_mt1]   ? mt1_2   : mt1_1;
    assign ppdc1_next = hit_3[fld_ppdc1] ? ppdc1_3 :
                        hit_2[fld_ppdc1] ? ppdc1_2 : ppdc1_1;
    assign ss5_next   = hit_3[fld_ss5]   ? ss5_3   :
                        hit_2[fld_ss5]   ? ss5_2   : ss5_1;
    assign sp4_next   = hit_3[fld_sp4]   ? sp4_3   :
                        hit_2[fld_sp4]   ? sp4_2   : sp4_1;
    assign v4_next    = hit_3[fld_v4]    ? v4_3    :
                        hit_2[fld_v4]    ? v4_2    : v4_1;
    assign ti4_next   = hit_3[fld_ti4]   ? ti4_3   :
                        hit_2[fld_ti4]   ? ti4_2   : ti4_1;
    assign oiv4_next  = hit_3[fld_oiv4]  ? oiv4_3  :
                        hit_2[fld_oiv4]  ? oiv4_2  : oiv4_1;
    assign bp4_next   = hit_3[fld_bp4]   ? bp4_3   :
                        hit_2[fld_bp4]   ? bp4_2   : bp4_1;
    assign bs4_next   = hit_3[fld_bs4]   ? bs4_3   :
                        hit_2[fld_bs4]   ? bs4_2   : bs4_1;

endmodule

`default_nettype wire

// ==== src/field_store.sv ====
`timescale 1ns/1ps
`default_nettype none

module field_store
    import field_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       message_en,
    input  field_hit_t field_we,
    input  flag_t      pid1_next,
    input  flag_t      mc1_next,
    input  flag_t      mt1_next,
    input  flag_t      ppdc1_next,
    input  ss_t        ss5_next,
    input  nibble_t    sp4_next,
    input  nibble_t    v4_next,
    input  nibble_t    ti4_next,
    input  nibble_t    oiv4_next,
    input  nibble_t    bp4_next,
    input  nibble_t    bs4_next,
    output flag_t      pid1,
    output flag_t      mc1,
    output flag_t      mt1,
    output flag_t      ppdc1,
    output ss_t        ss5,
    output nibble_t    sp4,
    output nibble_t    v4,
    output nibble_t    ti4,
    output nibble_t    oiv4,
    output nibble_t    bp4,
    output nibble_t    bs4
);

    always_ff @(posedge clk) begin
        if (rst) begin
            pid1  <= '0;
            mc1   <= '0;
            mt1   <= '0;
            ppdc1 <= '0;
            ss5   <= '0;
            sp4   <= '0;
            v4    <= '0;
            ti4   <= '0;
            oiv4  <= '0;
            bp4   <= '0;
            bs4   <= '0;
        end else if (message_en) begin
            // Fields no slot carried hold.
            if (field_we[fld_pid1])  pid1  <= pid1_next;
            if (field_we[fld_mc1])   mc1   <= mc1_next;
            if (field_we[fld_mt1])   mt1   <= mt1_next;
            if (field_we[fld_ppdc1]) ppdc1 <= ppdc1_next;
            if (field_we[fld_ss5])   ss5   <= ss5_next;
            if (field_we[fld_sp4])   sp4   <= sp4_next;
            if (field_we[fld_v4])    v4    <= v4_next;
            if (field_we[fld_ti4])   ti4   <= ti4_next;
            if (field_we[fld_oiv4])  oiv4  <= oiv4_next;
            if (field_we[fld_bp4])   bp4   <= bp4_next;
            if (field_we[fld_bs4])   bs4   <= bs4_next;
        end
    end

endmodule

`default_nettype wire

// ==== src/field_update_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module field_update_top
    import message_layout_pkg::*;
    import field_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  logic          message_en,
    input  message_t      message_1,
    input  message_t      message_2,
    input  message_t      message_3,
    input  message_kind_e kind_1,
    input  message_kind_e kind_2,
    input  message_kind_e kind_3,
    output flag_t         pid1,
    output flag_t         mc1,
    output flag_t         mt1,
    output flag_t         ppdc1,
    output ss_t           ss5,
    output nibble_t       sp4,
    output nibble_t       v4,
    output nibble_t       ti4,
    output nibble_t       oiv4,
    output nibble_t       bp4,
    output nibble_t       bs4
);

    field_hit_t hit_1, hit_2, hit_3, field_we;
    flag_t      pid1_1, pid1_2, pid1_3, pid1_next;
    flag_t      mc1_1, mc1_2, mc1_3, mc1_next;
    flag_t      mt1_1, mt1_2, mt1_3, mt1_next;
    flag_t      ppdc1_1, ppdc1_2, ppdc1_3, ppdc1_next;
    ss_t        ss5_1, ss5_2, ss5_3, ss5_next;
    nibble_t    sp4_1, sp4_2, sp4_3, sp4_next;
    nibble_t    v4_1, v4_2, v4_3, v4_next;
    nibble_t    ti4_1, ti4_2, ti4_3, ti4_next;
    nibble_t    oiv4_1, oiv4_2, oiv4_3, oiv4_next;
    nibble_t    bp4_1, bp4_2, bp4_3, bp4_next;
    nibble_t    bs4_1, bs4_2, bs4_3, bs4_next;

    message_slot_decode slot1_dec (
        .message(message_1), .kind(kind_1), .field_hit(hit_1),
        .pid1(pid1_1), .mc1(mc1_1), .mt1(mt1_1), .ppdc1(ppdc1_1), .ss5(ss5_1),
        .sp4(sp4_1), .v4(v4_1), .ti4(ti4_1), .oiv4(oiv4_1), .bp4(bp4_1), .bs4(bs4_1)
    );

    message_slot_decode slot2_dec (
        .message(message_2), .kind(kind_2), .field_hit(hit_2),
        .pid1(pid1_2), .mc1(mc1_2), .mt1(mt1_2), .ppdc1(ppdc1_2), .ss5(ss5_2),
        .sp4(sp4_2), .v4(v4_2), .ti4(ti4_2), .oiv4(oiv4_2), .bp4(bp4_2), .bs4(bs4_2)
    );

    message_slot_decode slot3_dec (
        .message(message_3), .kind(kind_3), .field_hit(hit_3),
        .pid1(pid1_3), .mc1(mc1_3), .mt1(mt1_3), .ppdc1(ppdc1_3), .ss5(ss5_3),
        .sp4(sp4_3), .v4(v4_3), .ti4(ti4_3), .oiv4(oiv4_3), .bp4(bp4_3), .bs4(bs4_3)
    );

    // Port names of merge and store match the wires here.
    field_priority_merge merge0 (.*);

    field_store store0 (.*);

endmodule

`default_nettype wire

// ==== verification/field_update_model.svh ====
`ifndef FIELD_UPDATE_MODEL_SVH
`define FIELD_UPDATE_MODEL_SVH

// One expected value per field, indexed by the field index constants.
typedef logic [num_fields-1:0][4:0] field_vals_t;

// Expected field values after one clock with the given set applied.
function automatic field_vals_t field_update_model(
    input field_vals_t   cur,
    input logic          en,
    input message_t      msg_1,
    input message_t      msg_2,
    input message_t      msg_3,
    input message_kind_e kind_1,
    input message_kind_e kind_2,
    input message_kind_e kind_3
);
    field_vals_t   nxt;
    message_t      msgs [3];
    message_kind_e kinds [3];
    message_t      m;
    int            s;

    nxt = cur;
    msgs[0] = msg_1;
    msgs[1] = msg_2;
    msgs[2] = msg_3;
    kinds[0] = kind_1;
    kinds[1] = kind_2;
    kinds[2] = kind_3;
    if (en) begin
        // Lowest slot first, so a higher slot overwrites it.
        for (s = 0; s < 3; s++) begin
            m = msgs[s];
            if (kinds[s] != kind_none) begin
                nxt[fld_pid1] = {4'b0, m[31]};
                nxt[fld_mc1]  = {4'b0, m[30]};
                nxt[fld_mt1]  = {4'b0, m[29]};
            end
            case (kinds[s])
                kind_a: begin
                    nxt[fld_ss5]   = m[28:24];
                    nxt[fld_sp4]   = {1'b0, m[23:20]};
                    nxt[fld_v4]    = {1'b0, m[19:16]};
                    nxt[fld_ti4]   = {1'b0, m[15:12]};
                    nxt[fld_ppdc1] = {4'b0, m[11]};
                end
                kind_d: begin
                    nxt[fld_ss5]  = m[28:24];
                    nxt[fld_sp4]  = {1'b0, m[23:20]};
                    nxt[fld_oiv4] = {1'b0, m[19:16]};
                end
                kind_k: begin
                    nxt[fld_sp4]   = {1'b0, m[28:25]};
                    nxt[fld_ss5]   = m[24:20];
                    nxt[fld_bp4]   = {1'b0, m[19:16]};
                    nxt[fld_bs4]   = {1'b0, m[15:12]};
                    nxt[fld_ppdc1] = {4'b0, m[11]};
                end
                default: ;
            endcase
        end
    end
    return nxt;
endfunction

`endif

// ==== verification/field_update_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module field_update_tb
    import message_layout_pkg::*;
    import field_pkg::*;
;

    localparam int num_sets      = 300;
    localparam int reset_timeout = 20;

    `include "field_update_model.svh"

    logic          clk;
    logic          rst;
    logic          message_en;
    message_t      message_1, message_2, message_3;
    message_kind_e kind_1, kind_2, kind_3;
    flag_t         pid1, mc1, mt1, ppdc1;
    ss_t           ss5;
    nibble_t       sp4, v4, ti4, oiv4, bp4, bs4;
    integer        seed;
    logic [31:0]   rnd;
    field_vals_t   expected;

    field_update_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [4:0] actual,
                               input logic [4:0] expect_val);
        if (actual !== expect_val) begin
            $display("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
                     $time, name, actual, expect_val);
            $display("TEST FAILED");
            $fatal(1, "Field %s mismatch", name);
        end
    endtask

    task automatic check_all_fields();
        check_value("pid1", {4'b0, pid1}, expected[fld_pid1]);
        check_value("mc1", {4'b0, mc1}, expected[fld_mc1]);
        check_value("mt1", {4'b0, mt1}, expected[fld_mt1]);
        check_value("ppdc1", {4'b0, ppdc1}, expected[fld_ppdc1]);
        check_value("ss5", ss5, expected[fld_ss5]);
        check_value("sp4", {1'b0, sp4}, expected[fld_sp4]);
        check_value("v4", {1'b0, v4}, expected[fld_v4]);
        check_value("ti4", {1'b0, ti4}, expected[fld_ti4]);
        check_value("oiv4", {1'b0, oiv4}, expected[fld_oiv4]);
        check_value("bp4", {1'b0, bp4}, expected[fld_bp4]);
        check_value("bs4", {1'b0, bs4}, expected[fld_bs4]);
    endtask

    function automatic message_kind_e random_kind();
        logic [31:0] r;
        r = $random(seed);
        return message_kind_e'(r[1:0]);
    endfunction

    // Drives one set, then holds it until 1 ns after the next edge.
    task automatic apply_set(input logic en, input message_t m1, input message_kind_e k1,
                             input message_t m2, input message_kind_e k2,
                             input message_t m3, input message_kind_e k3);
        message_en = en;
        message_1  = m1;
        kind_1     = k1;
        message_2  = m2;
        kind_2     = k2;
        message_3  = m3;
        kind_3     = k3;
        @(posedge clk);
        #1;
    endtask

    task automatic apply_random_set(input logic en);
        apply_set(en, $random(seed), random_kind(), $random(seed), random_kind(),
                  $random(seed), random_kind());
    endtask

    initial begin
        seed       = 32'h9fa3_c626;
        rst        = 1'b1;
        message_en = 1'b0;
        message_1  = '0;
        message_2  = '0;
        message_3  = '0;
        kind_1     = kind_none;
        kind_2     = kind_none;
        kind_3     = kind_none;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        // Disabled sets must leave the cleared fields alone.
        repeat (4) apply_random_set(1'b0);
        // Fill every field before the single-kind sets.
        apply_set(1'b1, $random(seed), kind_d, $random(seed), kind_a, $random(seed), kind_k);
        apply_set(1'b1, $random(seed), kind_a, '0, kind_none, '0, kind_none);
        apply_set(1'b1, $random(seed), kind_d, '0, kind_none, '0, kind_none);
        apply_set(1'b1, $random(seed), kind_k, '0, kind_none, '0, kind_none);
        apply_set(1'b1, $random(seed), kind_none, $random(seed), kind_none,
                  $random(seed), kind_none);
        repeat (num_sets) begin
            rnd = $random(seed);
            apply_random_set(rnd[0]);
        end
        // Last set still has to reach the outputs.
        apply_set(1'b0, '0, kind_none, '0, kind_none, '0, kind_none);
        @(posedge clk);
        $display("TEST OK");
        $finish;
    end

    initial begin : compare_proc
        int wait_cycles;
        wait_cycles = 0;
        @(posedge clk);
        while (rst) begin
            wait_cycles++;
            if (wait_cycles > reset_timeout) begin
                $display("Reset was never released within %0d cycles", reset_timeout);
                $display("TEST FAILED");
                $fatal(1, "Reset stuck high");
            end
            @(posedge clk);
        end
        expected = '0;
        forever begin
            // Inputs are stable at the edge, outputs by the falling edge.
            expected = field_update_model(expected, message_en, message_1, message_2,
                                          message_3, kind_1, kind_2, kind_3);
            @(negedge clk);
            check_all_fields();
            @(posedge clk);
        end
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+verification
src/message_layout_pkg.sv
src/field_pkg.sv
src/message_slot_decode.sv
src/field_priority_merge.sv
src/field_store.sv
src/field_update_top.sv
verification/field_update_tb.sv

// ==== Bender.yml ====
package:
  name: field_update

sources:
  - files:
      - src/message_layout_pkg.sv
      - src/field_pkg.sv
      - src/message_slot_decode.sv
      - src/field_priority_merge.sv
      - src/field_store.sv
      - src/field_update_top.sv
  - target: test
    include_dirs:
      - verification
    files:
      - verification/field_update_tb.sv
